// File: Makefile
# Verilator build and run of the FIR filter testbench

VERILATOR ?= verilator
TOP       ?= fir_tb
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
# keep running after an assertion error so the testbench reports it
RUN_ARGS  ?= +verilator+error+limit+100
PASS_TEXT ?= SIMULATION PASSED

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	-./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: include/fir_config.svh
// FIR build-time sizes; include wherever sample, coefficient or tap sizes are needed
`ifndef FIR_CONFIG_SVH
`define FIR_CONFIG_SVH

// sample width in bits, signed
`define FIR_DATA_W 16

// coefficient width in bits, signed
`define FIR_COEF_W 16

// tap count, power of two, at least 2
`define FIR_TAPS 8

// rounding right shift on the full sum
// Q1.15 coefficients give unity gain at 15
`define FIR_SHIFT 15

`endif

// File: project.f
+incdir+include
rtl/fir_pkg.sv
rtl/fir_stream_if.sv
rtl/shift_reg.sv
rtl/fir_tap_line.sv
rtl/fir_mac_pipe.sv
rtl/fir_out_stage.sv
rtl/fir_filter_top.sv
verif/fir_props.sv
verif/fir_tb.sv

// File: rtl/fir_filter_top.sv
// streaming FIR filter top level; plain stream and coefficient ports for system use
`timescale 1ns/1ps
`default_nettype none

`include "fir_config.svh"

module fir_filter_top (
  input  logic                            clk,
  input  logic                            rst,
  // sample input
  input  logic                            in_valid,
  output logic                            in_ready,
  input  logic [`FIR_DATA_W-1:0]          in_data,
  input  logic                            in_last,
  // filtered output
  output logic                            out_valid,
  input  logic                            out_ready,
  output logic [`FIR_DATA_W-1:0]          out_data,
  output logic                            out_last,
  // coefficient write port
  input  logic                            coef_we,
  input  logic [fir_pkg::tree_lvls-1:0]   coef_addr,
  input  logic [`FIR_COEF_W-1:0]          coef_data
);

  logic [`FIR_TAPS-1:0][`FIR_DATA_W-1:0] taps;

  ////////////////////
  // stage links
  ////////////////////

  // tap line to MAC, newest sample
  fir_stream_if #(.DW(`FIR_DATA_W)) tap_link ();
  // MAC to output, full-width sum
  fir_stream_if #(.DW(fir_pkg::acc_w)) sum_link ();

  ////////////////////
  // stages
  ////////////////////

  fir_tap_line u_tap_line (
    .clk      (clk),
    .rst      (rst),
    .in_valid (in_valid),
    .in_ready (in_ready),
    .in_data  (in_data),
    .in_last  (in_last),
    .taps     (taps),
    .link     (tap_link.src)
  );

  fir_mac_pipe u_mac_pipe (
    .clk       (clk),
    .rst       (rst),
    .taps      (taps),
    .tap_in    (tap_link.snk),
    .sum_out   (sum_link.src),
    .coef_we   (coef_we),
    .coef_addr (coef_addr),
    .coef_data (coef_data)
  );

  // also drives the stall back through sum_link ready
  fir_out_stage u_out_stage (
    .clk       (clk),
    .rst       (rst),
    .sum_in    (sum_link.snk),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_data  (out_data),
    .out_last  (out_last)
  );

endmodule

`default_nettype wire

// File: rtl/fir_mac_pipe.sv
// FIR multiply-accumulate pipeline; coefficient file, product registers and adder tree
`timescale 1ns/1ps
`default_nettype none

`include "fir_config.svh"

module fir_mac_pipe (
  input  logic                                    clk,
  input  logic                                    rst,
  input  logic [`FIR_TAPS-1:0][`FIR_DATA_W-1:0]   taps,
  fir_stream_if.snk                               tap_in,
  fir_stream_if.src                               sum_out,
  input  logic                                    coef_we,
  input  logic [fir_pkg::tree_lvls-1:0]           coef_addr,
  input  logic [`FIR_COEF_W-1:0]                  coef_data
);

  logic                           ena;
  logic signed [`FIR_COEF_W-1:0]  coef [`FIR_TAPS];
  logic [1:0]                     side_q;

  // global stall from the output stage
  assign ena          = sum_out.ready;
  assign tap_in.ready = ena;

  ////////////////////
  // coefficients
  ////////////////////

  // written only while the pipe is empty
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int k = 0; k < `FIR_TAPS; k++) begin
        coef[k] <= '0;
      end
    end else if (coef_we) begin
      coef[coef_addr] <= coef_data;
    end
  end

  ////////////////////
  // products and tree
  ////////////////////

  // level 0 holds the products, level l the pairwise sums
  // level l has FIR_TAPS >> l nodes, top level is the single sum
  genvar l, i;
  for (l = 0; l <= fir_pkg::tree_lvls; l++) begin : g_lvl

    localparam int NODES = `FIR_TAPS >> l;

    logic signed [fir_pkg::acc_w-1:0] node [NODES];

    if (l == 0) begin : g_prod
      for (i = 0; i < NODES; i++) begin : g_mul

        logic [`FIR_DATA_W-1:0] sample;

        // newest sample comes on the link, older ones from the history
        if (i == 0) begin : g_new
          assign sample = tap_in.data;
        end else begin : g_old
          assign sample = taps[i];
        end

        // both operands signed, extended to acc_w before multiply
        always_ff @(posedge clk) begin
          if (ena) begin
            node[i] <= $signed(sample) * coef[i];
          end
        end
      end
    end else begin : g_add
      for (i = 0; i < NODES; i++) begin : g_sum
        // acc_w has headroom for every level
        always_ff @(posedge clk) begin
          if (ena) begin
            node[i] <= g_lvl[l-1].node[2*i] + g_lvl[l-1].node[2*i+1];
          end
        end
      end
    end

  end

  assign sum_out.data = g_lvl[fir_pkg::tree_lvls].node[0];

  ////////////////////
  // sideband
  ////////////////////

  // valid and last follow the data through mac_lat stages
  shift_reg #(
    .WIDTH (2),
    .DEPTH (fir_pkg::mac_lat)
  ) u_side (
    .clk  (clk),
    .rst  (rst),
    .ena  (ena),
    .din  ({tap_in.valid, tap_in.last}),
    .dout (side_q)
  );

  assign sum_out.valid = side_q[1];
  assign sum_out.last  = side_q[0];

endmodule

`default_nettype wire

// File: rtl/fir_out_stage.sv
// FIR output stage; round, saturate and hold the result, source of the global stall
`timescale 1ns/1ps
`default_nettype none

`include "fir_config.svh"

module fir_out_stage (
  input  logic                     clk,
  input  logic                     rst,
  fir_stream_if.snk                sum_in,
  output logic                     out_valid,
  input  logic                     out_ready,
  output logic [`FIR_DATA_W-1:0]   out_data,
  output logic                     out_last
);

  logic ena;
  logic load;

  ////////////////////
  // stall
  ////////////////////

  // free to advance when empty or being drained
  assign ena          = ~out_valid | out_ready;
  assign sum_in.ready = ena;

  // new result captured this edge
  assign load = ena & sum_in.valid;

  ////////////////////
  // output register
  ////////////////////

  // empties when taken with nothing behind it
  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid <= 1'b0;
    end else if (ena) begin
      out_valid <= sum_in.valid;
    end
  end

  // payload, held while stalled
  always_ff @(posedge clk) begin
    if (load) begin
      out_data <= fir_pkg::sat_round(sum_in.data);
      out_last <= sum_in.last;
    end
  end

endmodule

`default_nettype wire

// File: rtl/fir_pkg.sv
// shared FIR widths, pipeline latency and output rounding; referenced by scoped names
`default_nettype none

`include "fir_config.svh"

package fir_pkg;

  ////////////////////
  // derived sizes
  ////////////////////

  // adder tree depth, also coefficient address width
  localparam int tree_lvls = $clog2(`FIR_TAPS);

  // full-precision sum, no overflow possible
  localparam int acc_w = `FIR_DATA_W + `FIR_COEF_W + tree_lvls;

  // product register plus one register per tree level
  localparam int mac_lat = 1 + tree_lvls;

  ////////////////////
  // round and saturate
  ////////////////////

  // one guard bit above acc_w for the rounding add
  localparam logic signed [acc_w:0] rnd_half =
    (`FIR_SHIFT > 0) ? ((acc_w + 1)'(1) <<< (`FIR_SHIFT - 1)) : '0;
  localparam logic signed [acc_w:0] sat_max =
    $signed({{(acc_w - `FIR_DATA_W + 2){1'b0}}, {(`FIR_DATA_W - 1){1'b1}}});
  localparam logic signed [acc_w:0] sat_min = -sat_max - 1;

  function automatic logic signed [`FIR_DATA_W-1:0] sat_round(
    input logic signed [acc_w-1:0] sum
  );
    logic signed [acc_w:0] rounded;
    logic signed [acc_w:0] shifted;
    // round half up, then drop the fraction bits
    rounded = sum + rnd_half;
    shifted = rounded >>> `FIR_SHIFT;
    // clamp to the signed sample range
    if (shifted > sat_max) begin
      return sat_max[`FIR_DATA_W-1:0];
    end else if (shifted < sat_min) begin
      return sat_min[`FIR_DATA_W-1:0];
    end
    return shifted[`FIR_DATA_W-1:0];
  endfunction

endpackage

`default_nettype wire

// File: rtl/fir_stream_if.sv
// valid/ready stream link between FIR stages; one instance per internal hop
`timescale 1ns/1ps
`default_nettype none

interface fir_stream_if #(
  parameter int DW = 16
);

  // transfer on an edge with valid and ready both high
  logic          valid;
  logic          ready;
  logic [DW-1:0] data;
  // marks the final item of a packet
  logic          last;

  // producer side, holds data and last while stalled
  modport src (
    output valid,
    output data,
    output last,
    input  ready
  );

  // consumer side
  modport snk (
    input  valid,
    input  data,
    input  last,
    output ready
  );

endinterface

`default_nettype wire

// File: rtl/fir_tap_line.sv
// FIR input stage; accepts samples and keeps the tap history for the MAC pipeline
`timescale 1ns/1ps
`default_nettype none

`include "fir_config.svh"

module fir_tap_line (
  input  logic                                    clk,
  input  logic                                    rst,
  input  logic                                    in_valid,
  output logic                                    in_ready,
  input  logic [`FIR_DATA_W-1:0]                  in_data,
  input  logic                                    in_last,
  // tap 0 is the newest sample
  output logic [`FIR_TAPS-1:0][`FIR_DATA_W-1:0]   taps,
  fir_stream_if.src                               link
);

  logic                                   in_xfer;
  logic [`FIR_TAPS-1:0][`FIR_DATA_W-1:0]  hist_next;
  logic [1:0]                             side_q;

  // stall ena comes back on the link ready
  assign in_ready = link.ready;
  assign in_xfer  = in_valid & in_ready;

  ////////////////////
  // sample history
  ////////////////////

  // new sample in at tap 0, oldest falls off the top
  assign hist_next = {taps[`FIR_TAPS-2:0], in_data};

  // whole history as one register word, moves only on accepted input
  shift_reg #(
    .WIDTH (`FIR_TAPS * `FIR_DATA_W),
    .DEPTH (1)
  ) u_hist (
    .clk  (clk),
    .rst  (rst),
    .ena  (in_xfer),
    .din  (hist_next),
    .dout (taps)
  );

  ////////////////////
  // sideband
  ////////////////////

  // valid and last, one cycle behind the accept
  // frozen together with the rest of the pipe on stall
  shift_reg #(
    .WIDTH (2),
    .DEPTH (1)
  ) u_side (
    .clk  (clk),
    .rst  (rst),
    .ena  (link.ready),
    .din  ({in_valid, in_last}),
    .dout (side_q)
  );

  assign link.valid = side_q[1];
  assign link.last  = side_q[0];
  // newest sample rides on the link, full history on taps
  assign link.data  = taps[0];

endmodule

`default_nettype wire

// File: rtl/shift_reg.sv
// enable-gated register delay line, latency DEPTH; used for sideband and tap history
`timescale 1ns/1ps
`default_nettype none

module shift_reg #(
  parameter int WIDTH = 1,
  // DEPTH 1 means a single register
  parameter int DEPTH = 7
) (
  input  logic             clk,
  input  logic             rst,
  input  logic             ena,
  input  logic [WIDTH-1:0] din,
  output logic [WIDTH-1:0] dout
);

  ////////////////////
  // one chain per bit
  ////////////////////

  genvar n;
  for (n = 0; n < WIDTH; n++) begin : g_bit

    // stage 0 takes din, top stage drives dout
    logic [DEPTH-1:0] stage;

    always_ff @(posedge clk) begin
      if (rst) begin
        stage <= '0;
      end else if (ena) begin
        // shift toward msb, truncation drops the oldest bit
        stage <= DEPTH'({stage, din[n]});
      end
    end

    assign dout[n] = stage[DEPTH-1];

  end

endmodule

`default_nettype wire

// File: verif/fir_props.sv
// handshake and reset properties of the FIR top level; attached to fir_filter_top by bind
`timescale 1ns/1ps
`default_nettype none

`include "fir_config.svh"

module fir_props (
  input logic                   clk,
  input logic                   rst,
  input logic                   in_valid,
  input logic                   in_ready,
  input logic                   out_valid,
  input logic                   out_ready,
  input logic [`FIR_DATA_W-1:0] out_data,
  input logic                   out_last
);

  // accept edge to first edge that samples out_valid high
  localparam int LAT = 2 + fir_pkg::mac_lat;

  // failures seen so far, polled by the testbench
  int unsigned fail_count = 0;

  // consecutive edges with out_ready high, saturating
  logic [7:0] ready_run;

  always_ff @(posedge clk) begin
    if (rst || !out_ready) begin
      ready_run <= '0;
    end else if (ready_run != '1) begin
      ready_run <= ready_run + 8'd1;
    end
  end

  ////////////////////
  // reset
  ////////////////////

  a_reset_clears: assert property (@(posedge clk) rst |=> !out_valid)
    else begin
      $error("out_valid high during or right after reset");
      fail_count++;
    end

  ////////////////////
  // handshake
  ////////////////////

  // stalled output holds its payload
  a_hold_stable: assert property (@(posedge clk) disable iff (rst)
    out_valid && !out_ready |=> out_valid && $stable(out_data) && $stable(out_last))
    else begin
      $error("output changed while stalled");
      fail_count++;
    end

  // global stall seen at the input
  a_ready_stall: assert property (@(posedge clk) disable iff (rst)
    in_ready == (!out_valid || out_ready))
    else begin
      $error("in_ready does not follow the output stall");
      fail_count++;
    end

  // fixed latency, only checked when out_ready stayed high the whole way
  a_fixed_latency: assert property (@(posedge clk) disable iff (rst)
    in_valid && in_ready |-> ##LAT (out_valid || ready_run < 8'(LAT)))
    else begin
      $error("out_valid missing at fixed latency");
      fail_count++;
    end

endmodule

bind fir_filter_top fir_props u_props (
  .clk       (clk),
  .rst       (rst),
  .in_valid  (in_valid),
  .in_ready  (in_ready),
  .out_valid (out_valid),
  .out_ready (out_ready),
  .out_data  (out_data),
  .out_last  (out_last)
);

`default_nettype wire

// File: verif/fir_tb.sv
// FIR filter testbench; run as top fir_tb, drives fir_filter_top and checks it against a model
`timescale 1ns/1ps
`default_nettype none

`include "fir_config.svh"

module fir_tb;

  localparam int DW    = `FIR_DATA_W;
  localparam int CW    = `FIR_COEF_W;
  localparam int TAPS  = `FIR_TAPS;
  localparam int SHIFT = `FIR_SHIFT;
  localparam int AW    = fir_pkg::tree_lvls;
  localparam longint SMAX = (longint'(1) <<< (DW - 1)) - 1;
  localparam longint SMIN = -(longint'(1) <<< (DW - 1));
  localparam longint CMAX = (longint'(1) <<< (CW - 1)) - 1;
  // unit impulse in output scale, clipped to the sample range
  localparam longint IMPULSE = (SHIFT < DW - 1) ? (longint'(1) <<< SHIFT) : SMAX;
  localparam int N_RAND = 64;
  localparam int N_BP   = 96;
  localparam int N_LAST = 24;
  localparam int N_SAMPLES = 1 + 2 * TAPS + 1 + N_RAND + 2 * TAPS + N_BP + N_LAST;
  // reset, three coefficient loads, one cycle per sample
  localparam int STIM_CYCLES = 16 + 3 * TAPS + N_SAMPLES;

  logic          clk = 1'b0;
  logic          rst;
  logic          in_valid;
  logic          in_ready;
  logic [DW-1:0] in_data;
  logic          in_last;
  logic          out_valid;
  logic          out_ready;
  logic [DW-1:0] out_data;
  logic          out_last;
  logic          coef_we;
  logic [AW-1:0] coef_addr;
  logic [CW-1:0] coef_data;

  string         test_name;

  // model state
  longint        model_hist [TAPS];
  longint        model_coef [TAPS];
  logic [DW-1:0] exp_data_q [$];
  logic          exp_last_q [$];

  always #5 clk = ~clk;

  fir_filter_top dut (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .in_data   (in_data),
    .in_last   (in_last),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_data  (out_data),
    .out_last  (out_last),
    .coef_we   (coef_we),
    .coef_addr (coef_addr),
    .coef_data (coef_data)
  );

  ////////////////////
  // helpers
  ////////////////////

  task automatic stop_with_failure(input string why);
    $display("%s", why);
    $display("SIMULATION FAILED");
    $fatal(1);
  endtask

  // round half up at SHIFT, clamp to sample range
  function automatic longint round_clamp(input longint sum);
    longint r;
    r = sum;
    if (SHIFT > 0) begin
      r = (sum + (longint'(1) <<< (SHIFT - 1))) >>> SHIFT;
    end
    if (r > SMAX) begin
      r = SMAX;
    end else if (r < SMIN) begin
      r = SMIN;
    end
    return r;
  endfunction

  // called just after a rising edge, returns just after the write edge
  task automatic write_coef(input int addr, input longint value);
    coef_we   <= 1'b1;
    coef_addr <= AW'(addr);
    coef_data <= CW'(value);
    @(posedge clk);
    coef_we   <= 1'b0;
  endtask

  task automatic load_random_coefs();
    for (int k = 0; k < TAPS; k++) begin
      write_coef(k, longint'($urandom));
    end
  endtask

  // random idle gap, then valid held until accepted
  task automatic send_sample(input logic [DW-1:0] data, input logic last,
                             input int idle_pct, input bit stall);
    while (int'($urandom_range(99)) < idle_pct) begin
      in_valid <= 1'b0;
      if (stall) out_ready <= 1'($urandom_range(1));
      @(posedge clk);
    end
    in_valid <= 1'b1;
    in_data  <= data;
    in_last  <= last;
    do begin
      if (stall) out_ready <= 1'($urandom_range(1));
      @(posedge clk);
    end while (!in_ready);
    in_valid <= 1'b0;
  endtask

  // empty pipe, queue read on the falling edge
  task automatic drain();
    out_ready <= 1'b1;
    in_valid  <= 1'b0;
    @(negedge clk);
    while (exp_data_q.size() != 0) @(negedge clk);
    @(posedge clk);
  endtask

  ////////////////////
  // model and output check
  ////////////////////

  always @(posedge clk) begin : monitor
    logic [DW-1:0] exp_d;
    logic          exp_l;
    longint        acc;
    if (rst) begin
      for (int k = 0; k < TAPS; k++) begin
        model_hist[k] = 0;
        model_coef[k] = 0;
      end
    end else begin
      if (coef_we) model_coef[coef_addr] = longint'($signed(coef_data));
      if (in_valid && in_ready) begin
        // newest at tap 0
        for (int k = TAPS - 1; k > 0; k--) model_hist[k] = model_hist[k - 1];
        model_hist[0] = longint'($signed(in_data));
        acc = 0;
        for (int k = 0; k < TAPS; k++) acc += model_hist[k] * model_coef[k];
        exp_data_q.push_back(DW'(round_clamp(acc)));
        exp_last_q.push_back(in_last);
      end
      if (out_valid && out_ready) begin
        if (exp_data_q.size() == 0) begin
          stop_with_failure($sformatf("output transfer in %s with no sample pending", test_name));
        end else begin
          exp_d = exp_data_q.pop_front();
          exp_l = exp_last_q.pop_front();
          assert (out_data == exp_d) else stop_with_failure($sformatf(
            "[FAIL] %s: out_data expected %0d actual %0d", test_name, $signed(exp_d),
            $signed(out_data)));
          assert (out_last == exp_l) else stop_with_failure($sformatf(
            "[FAIL] %s: out_last expected %0b actual %0b", test_name, exp_l, out_last));
        end
      end
    end
  end

  // property failures from the bound checker
  always @(negedge clk) begin
    if (dut.u_props.fail_count != 0) begin
      stop_with_failure($sformatf("concurrent assertion failed during %s", test_name));
    end
  end

  initial begin : watchdog
    repeat (20 * STIM_CYCLES) @(posedge clk);
    stop_with_failure($sformatf("timeout in %s, outputs never drained", test_name));
  end

  ////////////////////
  // stimulus
  ////////////////////

  initial begin : stimulus
    void'($urandom(32'hc4de));
    rst       <= 1'b1;
    in_valid  <= 1'b0;
    in_data   <= '0;
    in_last   <= 1'b0;
    out_ready <= 1'b1;
    coef_we   <= 1'b0;
    coef_addr <= '0;
    coef_data <= '0;
    test_name = "reset_state";
    repeat (16) @(posedge clk);
    rst <= 1'b0;
    @(posedge clk);
    assert (out_valid == 1'b0) else stop_with_failure($sformatf(
      "[FAIL] %s: out_valid expected 0 actual %0b", test_name, out_valid));
    assert (in_ready == 1'b1) else stop_with_failure($sformatf(
      "[FAIL] %s: in_ready expected 1 actual %0b", test_name, in_ready));
    // zero coefficients give zero
    send_sample(DW'(1234), 1'b0, 0, 1'b0);
    drain();

    test_name = "impulse";
    load_random_coefs();
    // flush history, then impulse and zeros
    for (int k = 0; k < TAPS; k++) send_sample('0, 1'b0, 0, 1'b0);
    send_sample(DW'(IMPULSE), 1'b0, 0, 1'b0);
    for (int k = 0; k < TAPS; k++) send_sample('0, 1'b0, 0, 1'b0);
    drain();

    test_name = "random_stream";
    for (int i = 0; i < N_RAND; i++) begin
      send_sample(DW'($urandom), $urandom_range(7) == 0, 0, 1'b0);
    end
    drain();

    // largest positive coefficients against both rails
    test_name = "saturation";
    for (int k = 0; k < TAPS; k++) write_coef(k, CMAX);
    for (int k = 0; k < TAPS; k++) send_sample(DW'(SMAX), 1'b0, 0, 1'b0);
    for (int k = 0; k < TAPS; k++) send_sample(DW'(SMIN), 1'b0, 0, 1'b0);
    drain();

    test_name = "back_pressure";
    load_random_coefs();
    for (int i = 0; i < N_BP; i++) begin
      send_sample(DW'($urandom), $urandom_range(7) == 0, 30, 1'b1);
    end
    drain();

    // packet end on every fourth sample
    test_name = "last_alignment";
    for (int i = 0; i < N_LAST; i++) begin
      send_sample(DW'($urandom), (i % 4) == 3, 20, 1'b1);
    end
    drain();

    repeat (4) @(posedge clk);
    if (exp_data_q.size() == 0 && dut.u_props.fail_count == 0) begin
      $display("SIMULATION PASSED");
      $finish;
    end else begin
      stop_with_failure($sformatf("end of run with %0d outputs pending", exp_data_q.size()));
    end
  end

endmodule

`default_nettype wire
